/* tb/dly_testdata.txt */
// columns: test id, op (0 check, 1 load, 2 inc, 3 dec, 4 held inc), sel, tap,
// expected readback tap of sel after the step; all values hex
01 00 00 00 00
01 00 01 00 00
01 00 02 00 00
01 00 03 00 00
02 01 00 2a 2a
02 01 01 15 15
02 01 02 3f 3f
02 01 03 07 07
02 00 00 00 2a
02 00 02 00 3f
03 02 03 00 08
03 02 03 00 09
03 03 00 00 29
03 04 01 00 16
04 02 02 00 3f
04 01 01 01 01
04 03 01 00 00
04 03 01 00 00
05 01 00 05 05
05 01 01 11 11
05 01 02 28 28
05 01 03 3f 3f

/* tb.f */
common/dly_cfg_pkg.sv
common/dly_cmd_pkg.sv
common/dly_ctrl_if.sv
src/dly_cmd_decoder.sv
dly_chan/dly_chan.sv
src/dly_tap_readback.sv
src/dly_ctrl_top.sv
tb/dly_ctrl_chk.sv
tb/dly_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the delay block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
    --top-module dly_ctrl_tb -Mdir obj_dir -o dly_ctrl_sim -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/dly_ctrl_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^ALL TESTS PASSED$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tb/dly_ctrl_tb.sv */
//**************************************************************************
// testbench for the programmable data delay block
// replays command steps from the data file, checks the tap readback, then
// feeds LFSR data and checks every delayed bit against a history model
//**************************************************************************

module dly_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dly_cfg_pkg::*;

    localparam int NUM_STEPS      = 22;
    localparam int NUM_FIELDS     = 5;      // id, op, sel, tap, expected tap
    localparam int DATA_CYCLES    = 200;
    localparam int TIMEOUT_CYCLES = NUM_STEPS * 4 + DLY_DEPTH * NUM_DLY + 50;

    logic                     clk_i_buf;
    logic                     reset_buf;
    logic [DLY_SEL_WIDTH-1:0] sel_dly_i;
    logic [NUM_DLY/2-1:0]     din_idly_i;
    logic [NUM_DLY/2-1:0]     din_odly_i;
    dly_tap_t                 g2f_trx_dly_tap_i;
    logic                     dly_incdec_i;
    logic                     dly_ld_i;
    logic                     dly_adj_i;
    logic [NUM_DLY-1:0]       data_delayed_o;
    dly_tap_t                 dly_tap_val_o;

    logic [7:0]           step_mem [NUM_STEPS*NUM_FIELDS];
    dly_tap_t             tap_m [NUM_DLY];          // expected channel taps
    logic [DLY_DEPTH-1:0] hist_m [NUM_DLY];         // bit 0 newest sample
    logic [15:0]          lfsr_q;
    int cycle_cnt = 0;
    int check_cnt = 0;
    int err_cnt = 0;
    int test_err_cnt = 0;
    int tests_run = 0;
    int tests_failed = 0;

    dly_ctrl_top UUT (
        .clk_i_buf         (clk_i_buf),
        .reset_buf         (reset_buf),
        .sel_dly_i         (sel_dly_i),
        .din_idly_i        (din_idly_i),
        .din_odly_i        (din_odly_i),
        .g2f_trx_dly_tap_i (g2f_trx_dly_tap_i),
        .dly_incdec_i      (dly_incdec_i),
        .dly_ld_i          (dly_ld_i),
        .dly_adj_i         (dly_adj_i),
        .data_delayed_o    (data_delayed_o),
        .dly_tap_val_o     (dly_tap_val_o)
    );

    always #10 clk_i_buf = ~clk_i_buf;

    always @(posedge clk_i_buf) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles before all steps finished", cycle_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //**********************************************************************
    // reference model
    //**********************************************************************
    // 16-bit fibonacci lfsr, x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic dly_tap_t model_tap(input dly_tap_t cur, input logic [7:0] op,
                                           input dly_tap_t ld);
        case (op)
            8'd1:       return ld;
            8'd2, 8'd4: return (cur == dly_tap_t'(DLY_TAP_MAX)) ? cur : cur + 6'd1;
            8'd3:       return (cur == 6'd0) ? cur : cur - 6'd1;
            default:    return cur;
        endcase
    endfunction

    task automatic take_bit(output logic b);
        lfsr_q = lfsr_step(lfsr_q);
        b = lfsr_q[0];
    endtask

    task automatic check_data();
        logic [NUM_DLY-1:0] exp_data;
        exp_data = '0;
        for (int k = 0; k < NUM_DLY; k++)
            exp_data[DLY_OUT_BIT[k]] = hist_m[k][tap_m[k]];
        check_cnt++;
        assert (data_delayed_o == exp_data) else begin
            $display("FAIL t=%0t: data_delayed_o %b, expected %b",
                     $time, data_delayed_o, exp_data);
            test_err_cnt++;
        end
    endtask

    // one clock, history model follows the driven bits, inputs change at +2
    task automatic tick();
        logic [NUM_DLY-1:0] din_now;
        @(posedge clk_i_buf);
        din_now = {din_odly_i, din_idly_i};     // chan 0,1 idly then 2,3 odly
        for (int k = 0; k < NUM_DLY; k++)
            hist_m[k] = reset_buf ? {hist_m[k][DLY_DEPTH-2:0], din_now[k]} : '0;
        #2;
        check_data();
    endtask

    //**********************************************************************
    // stimulus
    //**********************************************************************
    task automatic run_step(input logic [7:0] op, input logic [DLY_SEL_WIDTH-1:0] sel,
                            input dly_tap_t tap, input dly_tap_t exp_tap);
        int hold;
        hold = (op == 8'd4) ? 3 : 1;            // held adjust still one step
        sel_dly_i = sel;
        g2f_trx_dly_tap_i = tap;
        dly_ld_i = (op == 8'd1);
        dly_adj_i = (op >= 8'd2);
        dly_incdec_i = (op == 8'd2) || (op == 8'd4);
        tap_m[sel] = model_tap(tap_m[sel], op, tap);
        repeat (hold) tick();
        dly_ld_i = 1'b0;
        dly_adj_i = 1'b0;
        repeat (2) tick();                      // decode, apply, readback
        check_cnt++;
        assert (dly_tap_val_o == exp_tap) else begin
            $display("FAIL t=%0t: readback sel %0d is %0d, expected %0d",
                     $time, sel, dly_tap_val_o, exp_tap);
            test_err_cnt++;
        end
        assert (tap_m[sel] == exp_tap) else begin
            $display("data file step disagrees with the tap rules on channel %0d", sel);
            test_err_cnt++;
        end
    endtask

    task automatic drive_data();
        logic b;
        for (int k = 0; k < NUM_DLY/2; k++) begin
            take_bit(b);
            din_idly_i[k] = b;
            take_bit(b);
            din_odly_i[k] = b;
        end
    endtask

    task automatic report_test(input logic [7:0] id);
        tests_run++;
        if (test_err_cnt != 0) begin
            tests_failed++;
            $display("test %0d: failed with %0d errors", id, test_err_cnt);
        end else begin
            $display("test %0d: passed", id);
        end
        err_cnt += test_err_cnt;
        test_err_cnt = 0;
    endtask

    initial begin
        logic [7:0] id;
        logic [7:0] prev_id;
        int         chk_fails;
        clk_i_buf = 1'b0;
        reset_buf = 1'b0;
        sel_dly_i = '0;
        din_idly_i = '0;
        din_odly_i = '0;
        g2f_trx_dly_tap_i = '0;
        dly_incdec_i = 1'b0;
        dly_ld_i = 1'b0;
        dly_adj_i = 1'b0;
        lfsr_q = 16'd50;
        for (int k = 0; k < NUM_DLY; k++) begin
            tap_m[k] = '0;
            hist_m[k] = '0;
        end
        $readmemh("tb/dly_testdata.txt", step_mem);

        repeat (2) tick();
        reset_buf = 1'b1;
        tick();                                 // idle cycle after release

        prev_id = step_mem[0];
        for (int i = 0; i < NUM_STEPS; i++) begin
            id = step_mem[i*NUM_FIELDS];
            if (id != prev_id) begin
                report_test(prev_id);
                prev_id = id;
            end
            run_step(step_mem[i*NUM_FIELDS+1], step_mem[i*NUM_FIELDS+2][DLY_SEL_WIDTH-1:0],
                     step_mem[i*NUM_FIELDS+3][5:0], step_mem[i*NUM_FIELDS+4][5:0]);
        end

        // taps now held, delayed data checked every cycle inside tick
        for (int n = 0; n < DATA_CYCLES; n++) begin
            drive_data();
            tick();
        end
        report_test(prev_id);

        // bound assertion failures in the four channels
        chk_fails = UUT.gen_chan[0].u_chan.u_tap_chk.fail_cnt
                  + UUT.gen_chan[1].u_chan.u_tap_chk.fail_cnt
                  + UUT.gen_chan[2].u_chan.u_tap_chk.fail_cnt
                  + UUT.gen_chan[3].u_chan.u_tap_chk.fail_cnt;

        $display("%0d tests run, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, check_cnt, err_cnt, chk_fails);
        if (tests_failed == 0 && chk_fails == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* tb/dly_ctrl_chk.sv */
//**************************************************************************
// command and tap checker
// concurrent assertions bound into each delay channel, on the broadcast
// command and the channel tap
//**************************************************************************

module dly_ctrl_chk (
    input logic                  clk_i_buf,
    input logic                  reset_buf,
    input dly_cmd_pkg::dly_op_e  op_i,
    input dly_cfg_pkg::dly_tap_t tap_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import dly_cfg_pkg::*;
    import dly_cmd_pkg::*;

    logic adj_op;
    int   fail_cnt = 0;     // failed assertions in this instance

    assign adj_op = (op_i == DLY_OP_INC) || (op_i == DLY_OP_DEC);

    quiet_after_reset: assert property (@(posedge clk_i_buf)
        $rose(reset_buf) |=> (op_i == DLY_OP_NONE))
        else begin
            fail_cnt++;
            $error("op issued in the first cycle after reset");
        end

    // one edge of adj gives one op only
    single_adjust: assert property (@(posedge clk_i_buf) disable iff (!reset_buf)
        adj_op |=> !adj_op)
        else begin
            fail_cnt++;
            $error("adjust op on two cycles in a row");
        end

    no_tap_wrap: assert property (@(posedge clk_i_buf) disable iff (!reset_buf)
        (op_i != DLY_OP_LOAD) |=>
            !((tap_i == '0 && $past(tap_i) == dly_tap_t'(DLY_TAP_MAX)) ||
              (tap_i == dly_tap_t'(DLY_TAP_MAX) && $past(tap_i) == '0)))
        else begin
            fail_cnt++;
            $error("tap wrapped between 0 and max on a single step");
        end

endmodule

bind dly_chan dly_ctrl_chk u_tap_chk (
    .clk_i_buf (clk_i_buf),
    .reset_buf (reset_buf),
    .op_i      (cmd.op),
    .tap_i     (tap_q)
);

/* src/dly_ctrl_top.sv */
//**************************************************************************
// programmable data delay top
// command decoder, four delay channels and tap readback, with the delayed
// input-side and output-side bits interleaved on the data output
//**************************************************************************

module dly_ctrl_top (
    input  logic                                  clk_i_buf,
    input  logic                                  reset_buf,
    input  dly_cmd_pkg::dly_chan_t                sel_dly_i,
    input  logic [dly_cfg_pkg::NUM_DLY/2-1:0]     din_idly_i,
    input  logic [dly_cfg_pkg::NUM_DLY/2-1:0]     din_odly_i,
    input  dly_cfg_pkg::dly_tap_t                 g2f_trx_dly_tap_i,
    input  logic                                  dly_incdec_i,
    input  logic                                  dly_ld_i,
    input  logic                                  dly_adj_i,
    output logic [dly_cfg_pkg::NUM_DLY-1:0]       data_delayed_o,
    output dly_cfg_pkg::dly_tap_t                 dly_tap_val_o
);
    import dly_cfg_pkg::*;

    localparam int HALF = NUM_DLY / 2;

    logic [NUM_DLY-1:0] chan_din;
    logic [NUM_DLY-1:0] chan_dout;

    dly_ctrl_if ctrl ();

    dly_cmd_decoder u_decoder (
        .clk_i_buf    (clk_i_buf),
        .reset_buf    (reset_buf),
        .sel_dly_i    (sel_dly_i),
        .dly_tap_i    (g2f_trx_dly_tap_i),
        .dly_incdec_i (dly_incdec_i),
        .dly_ld_i     (dly_ld_i),
        .dly_adj_i    (dly_adj_i),
        .cmd          (ctrl.cmd_src)
    );

    //**********************************************************************
    // delay channels, idly first then odly
    //**********************************************************************
    for (genvar g = 0; g < NUM_DLY; g++) begin : gen_chan
        if (g < HALF) begin : gen_idly
            assign chan_din[g] = din_idly_i[g];
        end else begin : gen_odly
            assign chan_din[g] = din_odly_i[g-HALF];
        end

        dly_chan #(.CHAN_IDX(DLY_SEL_WIDTH'(g))) u_chan (
            .clk_i_buf (clk_i_buf),
            .reset_buf (reset_buf),
            .din_i     (chan_din[g]),
            .cmd       (ctrl.chan),
            .dout_o    (chan_dout[g])
        );
    end

    // interleave onto the output bus
    always_comb begin
        data_delayed_o = '0;
        for (int k = 0; k < NUM_DLY; k++)
            data_delayed_o[DLY_OUT_BIT[k]] = chan_dout[k];
    end

    dly_tap_readback u_readback (
        .clk_i_buf     (clk_i_buf),
        .reset_buf     (reset_buf),
        .sel_dly_i     (sel_dly_i),
        .taps          (ctrl.rdbk),
        .dly_tap_val_o (dly_tap_val_o)
    );

endmodule

/* src/dly_tap_readback.sv */
//**************************************************************************
// tap readback
// registers the tap of the channel picked by the select input
//**************************************************************************

module dly_tap_readback (
    input  logic                   clk_i_buf,
    input  logic                   reset_buf,
    input  dly_cmd_pkg::dly_chan_t sel_dly_i,
    dly_ctrl_if.rdbk               taps,
    output dly_cfg_pkg::dly_tap_t  dly_tap_val_o
);

    // select sampled at the same edge as the tap, readback is continuous
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf)
            dly_tap_val_o <= '0;
        else
            dly_tap_val_o <= taps.tap[sel_dly_i];
    end

endmodule

/* dly_chan/dly_chan.sv */
//**************************************************************************
// delay channel
// saturating 6-bit tap register driven by the command broadcast, and a
// shift history that delays the data bit by tap+1 cycles
//**************************************************************************

module dly_chan #(
    parameter dly_cmd_pkg::dly_chan_t CHAN_IDX = '0
) (
    input  logic     clk_i_buf,
    input  logic     reset_buf,
    input  logic     din_i,
    dly_ctrl_if.chan cmd,
    output logic     dout_o
);
    import dly_cfg_pkg::*;
    import dly_cmd_pkg::*;

    dly_tap_t             tap_q;
    logic [DLY_DEPTH-1:0] hist_q;     // bit 0 is the newest sample
    logic                 hit;

    assign hit = (cmd.chan_sel == CHAN_IDX);

    //**********************************************************************
    // tap register
    //**********************************************************************
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf) begin
            tap_q <= '0;
        end else if (hit) begin
            case (cmd.op)
                DLY_OP_LOAD: tap_q <= cmd.load_tap;
                DLY_OP_INC: begin
                    if (tap_q != dly_tap_t'(DLY_TAP_MAX))
                        tap_q <= tap_q + 1'b1;      // stop at max
                end
                DLY_OP_DEC: begin
                    if (tap_q != '0)
                        tap_q <= tap_q - 1'b1;      // stop at zero
                end
                default: tap_q <= tap_q;
            endcase
        end
    end

    assign cmd.tap[CHAN_IDX] = tap_q;

    //**********************************************************************
    // data history
    //**********************************************************************
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf)
            hist_q <= '0;
        else
            hist_q <= {hist_q[DLY_DEPTH-2:0], din_i};
    end

    // hist_q[n] holds din from n+1 edges back
    assign dout_o = hist_q[tap_q];

endmodule

/* src/dly_cmd_decoder.sv */
//**************************************************************************
// delay command decoder
// samples the user strobes, finds adjust rising edges and issues a single
// opcode per cycle with load taking priority over adjust
//**************************************************************************

module dly_cmd_decoder (
    input  logic                   clk_i_buf,
    input  logic                   reset_buf,
    input  dly_cmd_pkg::dly_chan_t sel_dly_i,
    input  dly_cfg_pkg::dly_tap_t  dly_tap_i,
    input  logic                   dly_incdec_i,
    input  logic                   dly_ld_i,
    input  logic                   dly_adj_i,
    dly_ctrl_if.cmd_src            cmd
);
    import dly_cfg_pkg::*;
    import dly_cmd_pkg::*;

    dly_chan_t sel_q;
    dly_tap_t  tap_q;
    logic      ld_q;
    logic      adj_q;
    logic      adj_prev_q;     // adj level one sample back
    logic      incdec_q;
    logic      adj_rise;

    //**********************************************************************
    // input sampling
    //**********************************************************************
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf) begin
            sel_q      <= '0;
            tap_q      <= '0;
            ld_q       <= 1'b0;
            adj_q      <= 1'b0;
            adj_prev_q <= 1'b0;
            incdec_q   <= 1'b0;
        end else begin
            sel_q      <= sel_dly_i;
            tap_q      <= dly_tap_i;
            ld_q       <= dly_ld_i;
            adj_q      <= dly_adj_i;
            adj_prev_q <= adj_q;
            incdec_q   <= dly_incdec_i;
        end
    end

    assign adj_rise = adj_q & ~adj_prev_q;   // held adj gives one step only

    //**********************************************************************
    // opcode resolution
    //**********************************************************************
    always_comb begin
        if (ld_q)
            cmd.op = DLY_OP_LOAD;               // load wins over adjust
        else if (adj_rise)
            cmd.op = incdec_q ? DLY_OP_INC : DLY_OP_DEC;
        else
            cmd.op = DLY_OP_NONE;
    end

    assign cmd.chan_sel = sel_q;
    assign cmd.load_tap = tap_q;

endmodule

/* common/dly_ctrl_if.sv */
//**************************************************************************
// delay control interface
// carries the decoded command to the channels and the channel taps back
// to the readback logic
//**************************************************************************

interface dly_ctrl_if;
    import dly_cfg_pkg::*;
    import dly_cmd_pkg::*;

    dly_op_e   op;                 // valid for a single cycle
    dly_chan_t chan_sel;           // target channel of op
    dly_tap_t  load_tap;           // value for DLY_OP_LOAD
    dly_tap_t  tap [NUM_DLY];      // one entry per channel

    modport cmd_src (output op, output chan_sel, output load_tap);

    // each channel drives only its own tap entry
    modport chan (input op, input chan_sel, input load_tap, output tap);

    modport rdbk (input tap);

endinterface

/* common/dly_cmd_pkg.sv */
//**************************************************************************
// delay command package
// opcode broadcast from the command decoder and the channel index type
//**************************************************************************

package dly_cmd_pkg;

    // one opcode per cycle, NONE when idle
    typedef enum logic [1:0] {
        DLY_OP_NONE = 2'd0,
        DLY_OP_LOAD = 2'd1,
        DLY_OP_INC  = 2'd2,
        DLY_OP_DEC  = 2'd3
    } dly_op_e;

    typedef logic [dly_cfg_pkg::DLY_SEL_WIDTH-1:0] dly_chan_t;

endpackage

/* common/dly_cfg_pkg.sv */
//**************************************************************************
// delay configuration package
// tap and select widths, channel count, history depth and the map from
// delay channel to output data bit
//**************************************************************************

package dly_cfg_pkg;

    localparam int DLY_TAP_WIDTH = 6;
    localparam int DLY_TAP_MAX   = (1 << DLY_TAP_WIDTH) - 1;   // 63
    localparam int NUM_DLY       = 4;                          // split evenly in/out
    localparam int DLY_SEL_WIDTH = $clog2(NUM_DLY);
    localparam int DLY_DEPTH     = DLY_TAP_MAX + 1;            // one stage per tap

    typedef logic [DLY_TAP_WIDTH-1:0] dly_tap_t;

    // input-side delays land on even bits, output-side delays on odd bits
    //   chan 0 -> bit 0   (idly 0)
    //   chan 1 -> bit 2   (idly 1)
    //   chan 2 -> bit 1   (odly 0)
    //   chan 3 -> bit 3   (odly 1)
    localparam int DLY_OUT_BIT [NUM_DLY] = '{0, 2, 1, 3};

endpackage
